/* verilog/rv_issue_pkg.sv */
`default_nettype none

package rv_issue_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;   // 0 = no producer

    // Only the major opcodes this stage issues
    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_BR    = 7'b1100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_t;

    // funct3 values for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101;

    // Low bits are funct3, top bit marks SUB/SRA
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SLL = 4'b0001,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111,
        ALU_SUB = 4'b1000,
        ALU_SRA = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_t;

    typedef struct packed {
        word_t    value;
        logic     ready;
        rob_tag_t tag;     // zero when ready
    } operand_t;

    typedef struct packed {
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        rob_tag_t rob_tag;
    } alu_entry_t;

    typedef struct packed {
        cmp_op_t  op;
        logic     is_branch;
        operand_t src1;
        operand_t src2;
        word_t    pc;
        word_t    b_imm;
        rob_tag_t rob_tag;
    } cmp_entry_t;

    typedef struct packed {
        word_t    pc;
        opcode_t  opcode;
        reg_idx_t rd;
    } rob_entry_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
    } rat_update_t;

endpackage

`default_nettype wire

/* verilog/instr_fields.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fields (
    input  wire rv_issue_pkg::word_t   instr_i,
    output rv_issue_pkg::opcode_t      opcode_o,
    output rv_issue_pkg::reg_idx_t     rd_o,
    output rv_issue_pkg::reg_idx_t     rs1_o,
    output rv_issue_pkg::reg_idx_t     rs2_o,
    output logic [2:0]                 funct3_o,
    output logic                       alt_o,
    output rv_issue_pkg::word_t        i_imm_o,
    output rv_issue_pkg::word_t        b_imm_o,
    output rv_issue_pkg::word_t        u_imm_o
);

    assign opcode_o = rv_issue_pkg::opcode_t'(instr_i[6:0]);
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign alt_o    = instr_i[30];     // SUB / SRA select

    // Sign-extended immediates
    assign i_imm_o = {{20{instr_i[31]}}, instr_i[31:20]};

    assign b_imm_o = {
        {19{instr_i[31]}},
        instr_i[31],
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    assign u_imm_o = {instr_i[31:12], 12'h000};

endmodule

`default_nettype wire

/* verilog/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire rv_issue_pkg::word_t    rf_val_i,
    input  wire rv_issue_pkg::rob_tag_t rf_tag_i,
    input  wire [rv_issue_pkg::ROB_DEPTH-1:0] rob_done_i,
    input  wire rv_issue_pkg::word_t [rv_issue_pkg::ROB_DEPTH-1:0] rob_value_i,
    output rv_issue_pkg::operand_t      operand_o
);

    logic from_rob;

    // Producer already finished, value sits in the ROB
    assign from_rob = (rf_tag_i != '0) && rob_done_i[rf_tag_i];

    always_comb begin
        if (from_rob) begin
            operand_o.value = rob_value_i[rf_tag_i];
            operand_o.ready = 1'b1;
            operand_o.tag   = '0;
        end else begin
            operand_o.value = rf_val_i;
            operand_o.ready = (rf_tag_i == '0);
            operand_o.tag   = rf_tag_i;    // still waiting on producer
        end
    end

endmodule

`default_nettype wire

/* verilog/issue_control.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  wire                            iq_valid_i,
    input  wire rv_issue_pkg::opcode_t     opcode_i,
    input  wire rv_issue_pkg::reg_idx_t    rd_i,
    input  wire [2:0]                      funct3_i,
    input  wire                            alt_i,
    input  wire rv_issue_pkg::word_t       pc_i,
    input  wire rv_issue_pkg::word_t       i_imm_i,
    input  wire rv_issue_pkg::word_t       b_imm_i,
    input  wire rv_issue_pkg::word_t       u_imm_i,
    input  wire rv_issue_pkg::operand_t    src1_i,
    input  wire rv_issue_pkg::operand_t    src2_i,
    input  wire rv_issue_pkg::rob_tag_t    rob_free_tag_i,
    input  wire                            alu_full_i,
    input  wire                            cmp_full_i,
    output logic                           iq_read_o,
    output logic                           alu_load_o,
    output rv_issue_pkg::alu_entry_t       alu_entry_o,
    output logic                           cmp_load_o,
    output rv_issue_pkg::cmp_entry_t       cmp_entry_o,
    output logic                           rob_load_o,
    output rv_issue_pkg::rob_entry_t       rob_entry_o,
    output logic                           rat_load_o,
    output rv_issue_pkg::rat_update_t      rat_entry_o
);

    logic is_alu;
    logic is_cmp;       // SLT/SLTU, both forms
    logic is_branch;
    logic is_slt;
    logic room;
    logic discard;
    logic issue;
    rv_issue_pkg::operand_t imm_opnd;
    rv_issue_pkg::alu_op_t  grp_op;     // shared by OP and OP-IMM

    assign is_slt = (funct3_i == rv_issue_pkg::F3_SLT) || (funct3_i == rv_issue_pkg::F3_SLTU);

    always_comb begin
        is_alu    = 1'b0;
        is_cmp    = 1'b0;
        is_branch = 1'b0;
        case (opcode_i)
            rv_issue_pkg::OP_LUI, rv_issue_pkg::OP_AUIPC: is_alu = 1'b1;
            rv_issue_pkg::OP_IMM, rv_issue_pkg::OP_REG: begin
                is_alu = !is_slt;
                is_cmp = is_slt;
            end
            rv_issue_pkg::OP_BR: is_branch = 1'b1;
            default: ;
        endcase
    end

    assign room    = is_alu ? !alu_full_i : !cmp_full_i;
    assign discard = iq_valid_i && (((is_alu || is_cmp) && rd_i == '0)
                                    || !(is_alu || is_cmp || is_branch));
    assign issue   = iq_valid_i && !discard && room && (rob_free_tag_i != '0);

    assign iq_read_o  = issue || discard;   // pop in the decision cycle
    assign alu_load_o = issue && is_alu;
    assign cmp_load_o = issue && (is_cmp || is_branch);
    assign rob_load_o = issue;
    assign rat_load_o = issue && !is_branch;

    assign imm_opnd = '{value: i_imm_i, ready: 1'b1, tag: '0};

    always_comb begin
        if (funct3_i == rv_issue_pkg::F3_SR)
            grp_op = alt_i ? rv_issue_pkg::ALU_SRA : rv_issue_pkg::ALU_SRL;
        else if (funct3_i == rv_issue_pkg::F3_ADD && alt_i && opcode_i == rv_issue_pkg::OP_REG)
            grp_op = rv_issue_pkg::ALU_SUB;
        else
            grp_op = rv_issue_pkg::alu_op_t'({1'b0, funct3_i});
    end

    always_comb begin
        alu_entry_o.op      = grp_op;
        alu_entry_o.src1    = src1_i;
        alu_entry_o.src2    = (opcode_i == rv_issue_pkg::OP_REG) ? src2_i : imm_opnd;
        alu_entry_o.rob_tag = rob_free_tag_i;
        if (opcode_i == rv_issue_pkg::OP_LUI || opcode_i == rv_issue_pkg::OP_AUIPC) begin
            alu_entry_o.op   = rv_issue_pkg::ALU_ADD;
            alu_entry_o.src1 = '{value: '0, ready: 1'b1, tag: '0};
            alu_entry_o.src2 = '{value: u_imm_i, ready: 1'b1, tag: '0};
            if (opcode_i == rv_issue_pkg::OP_AUIPC)
                alu_entry_o.src1.value = pc_i;
        end
    end

    always_comb begin
        if (is_branch)
            cmp_entry_o.op = rv_issue_pkg::cmp_op_t'(funct3_i);
        else if (funct3_i == rv_issue_pkg::F3_SLTU)
            cmp_entry_o.op = rv_issue_pkg::CMP_LTU;
        else
            cmp_entry_o.op = rv_issue_pkg::CMP_LT;
        cmp_entry_o.is_branch = is_branch;
        cmp_entry_o.src1      = src1_i;
        cmp_entry_o.src2      = (opcode_i == rv_issue_pkg::OP_IMM) ? imm_opnd : src2_i;
        cmp_entry_o.pc        = pc_i;
        cmp_entry_o.b_imm     = is_branch ? b_imm_i : '0;
        cmp_entry_o.rob_tag   = rob_free_tag_i;
    end

    assign rob_entry_o = '{pc: pc_i, opcode: opcode_i, rd: (is_branch ? '0 : rd_i)};
    assign rat_entry_o = '{rd: rd_i, tag: rob_free_tag_i};

endmodule

`default_nettype wire

/* verilog/issue_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_slot #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           load_i,
    input  wire payload_t data_i,
    output logic          valid_o,
    output payload_t      data_o
);

    // One-cycle strobe per load
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            data_o <= data_i;   // held until the next issue
        end
    end

    // Payload built upstream must be fully defined when captured
    assert property (@(posedge clk) disable iff (rst) load_i |-> !$isunknown(data_i))
        else $error("Unknown payload bits on load");

endmodule

`default_nettype wire

/* verilog/decode_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  wire                                  clk,
    input  wire                                  rst,
    // Instruction queue
    input  wire                                  iq_valid_i,
    input  wire rv_issue_pkg::word_t             iq_instr_i,
    input  wire rv_issue_pkg::word_t             iq_pc_i,
    output logic                                 iq_read_o,
    // Register file
    output rv_issue_pkg::reg_idx_t               rs1_o,
    output rv_issue_pkg::reg_idx_t               rs2_o,
    input  wire rv_issue_pkg::word_t             rf_val1_i,
    input  wire rv_issue_pkg::rob_tag_t          rf_tag1_i,
    input  wire rv_issue_pkg::word_t             rf_val2_i,
    input  wire rv_issue_pkg::rob_tag_t          rf_tag2_i,
    output logic                                 rat_we_o,
    output rv_issue_pkg::reg_idx_t               rat_rd_o,
    output rv_issue_pkg::rob_tag_t               rat_tag_o,
    // Reorder buffer
    input  wire rv_issue_pkg::rob_tag_t          rob_free_tag_i,
    input  wire [rv_issue_pkg::ROB_DEPTH-1:0]    rob_done_i,
    input  wire rv_issue_pkg::word_t [rv_issue_pkg::ROB_DEPTH-1:0] rob_value_i,
    output logic                                 rob_we_o,
    output rv_issue_pkg::word_t                  rob_pc_o,
    output rv_issue_pkg::opcode_t                rob_opcode_o,
    output rv_issue_pkg::reg_idx_t               rob_rd_o,
    // Reservation stations
    input  wire                                  alu_full_i,
    input  wire                                  cmp_full_i,
    output logic                                 alu_valid_o,
    output rv_issue_pkg::alu_entry_t             alu_entry_o,
    output logic                                 cmp_valid_o,
    output rv_issue_pkg::cmp_entry_t             cmp_entry_o
);

    rv_issue_pkg::opcode_t     opcode;
    rv_issue_pkg::reg_idx_t    rd;
    logic [2:0]                funct3;
    logic                      alt;
    rv_issue_pkg::word_t       i_imm;
    rv_issue_pkg::word_t       b_imm;
    rv_issue_pkg::word_t       u_imm;
    rv_issue_pkg::operand_t    src1;
    rv_issue_pkg::operand_t    src2;
    logic                      iq_read;
    logic                      alu_load;
    logic                      cmp_load;
    logic                      rob_load;
    logic                      rat_load;
    rv_issue_pkg::alu_entry_t  alu_next;
    rv_issue_pkg::cmp_entry_t  cmp_next;
    rv_issue_pkg::rob_entry_t  rob_next;
    rv_issue_pkg::rob_entry_t  rob_q;
    rv_issue_pkg::rat_update_t rat_next;
    rv_issue_pkg::rat_update_t rat_q;

    instr_fields fields_i (
        .instr_i (iq_instr_i), .opcode_o (opcode), .rd_o (rd), .rs1_o (rs1_o),
        .rs2_o (rs2_o), .funct3_o (funct3), .alt_o (alt), .i_imm_o (i_imm),
        .b_imm_o (b_imm), .u_imm_o (u_imm)
    );

    operand_forward fwd1_i (
        .rf_val_i (rf_val1_i), .rf_tag_i (rf_tag1_i), .rob_done_i (rob_done_i),
        .rob_value_i (rob_value_i), .operand_o (src1)
    );

    operand_forward fwd2_i (
        .rf_val_i (rf_val2_i), .rf_tag_i (rf_tag2_i), .rob_done_i (rob_done_i),
        .rob_value_i (rob_value_i), .operand_o (src2)
    );

    issue_control ctrl_i (
        .iq_valid_i (iq_valid_i), .opcode_i (opcode), .rd_i (rd), .funct3_i (funct3),
        .alt_i (alt), .pc_i (iq_pc_i), .i_imm_i (i_imm), .b_imm_i (b_imm),
        .u_imm_i (u_imm), .src1_i (src1), .src2_i (src2),
        .rob_free_tag_i (rob_free_tag_i), .alu_full_i (alu_full_i),
        .cmp_full_i (cmp_full_i), .iq_read_o (iq_read),
        .alu_load_o (alu_load), .alu_entry_o (alu_next),
        .cmp_load_o (cmp_load), .cmp_entry_o (cmp_next),
        .rob_load_o (rob_load), .rob_entry_o (rob_next),
        .rat_load_o (rat_load), .rat_entry_o (rat_next)
    );

    assign iq_read_o = iq_read && !rst;    // No pop while in reset

    issue_slot #(.payload_t (rv_issue_pkg::alu_entry_t)) alu_slot_i (
        .clk (clk), .rst (rst), .load_i (alu_load), .data_i (alu_next),
        .valid_o (alu_valid_o), .data_o (alu_entry_o)
    );

    issue_slot #(.payload_t (rv_issue_pkg::cmp_entry_t)) cmp_slot_i (
        .clk (clk), .rst (rst), .load_i (cmp_load), .data_i (cmp_next),
        .valid_o (cmp_valid_o), .data_o (cmp_entry_o)
    );

    issue_slot #(.payload_t (rv_issue_pkg::rob_entry_t)) rob_slot_i (
        .clk (clk), .rst (rst), .load_i (rob_load), .data_i (rob_next),
        .valid_o (rob_we_o), .data_o (rob_q)
    );

    issue_slot #(.payload_t (rv_issue_pkg::rat_update_t)) rat_slot_i (
        .clk (clk), .rst (rst), .load_i (rat_load), .data_i (rat_next),
        .valid_o (rat_we_o), .data_o (rat_q)
    );

    assign rob_pc_o     = rob_q.pc;
    assign rob_opcode_o = rob_q.opcode;
    assign rob_rd_o     = rob_q.rd;
    assign rat_rd_o     = rat_q.rd;
    assign rat_tag_o    = rat_q.tag;

endmodule

`default_nettype wire

/* verification/decode_issue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_issue_tb;

    localparam int NUM_CYCLES    = 3000;
    localparam int RESET_TIMEOUT = 50;

    logic clk = 1'b0;
    logic rst;
    logic iq_valid;
    logic iq_read;
    logic alu_full;
    logic cmp_full;
    logic rat_we;
    logic rob_we;
    logic alu_valid;
    logic cmp_valid;
    rv_issue_pkg::word_t         iq_instr;
    rv_issue_pkg::word_t         iq_pc;
    rv_issue_pkg::reg_idx_t      rs1;
    rv_issue_pkg::reg_idx_t      rs2;
    rv_issue_pkg::word_t         rf_val1;
    rv_issue_pkg::word_t         rf_val2;
    rv_issue_pkg::rob_tag_t      rf_tag1;
    rv_issue_pkg::rob_tag_t      rf_tag2;
    rv_issue_pkg::reg_idx_t      rat_rd;
    rv_issue_pkg::rob_tag_t      rat_tag;
    rv_issue_pkg::rob_tag_t      rob_free_tag;
    logic [rv_issue_pkg::ROB_DEPTH-1:0] rob_done;
    rv_issue_pkg::word_t [rv_issue_pkg::ROB_DEPTH-1:0] rob_value;
    rv_issue_pkg::word_t         rob_pc;
    rv_issue_pkg::opcode_t       rob_opcode;
    rv_issue_pkg::reg_idx_t      rob_rd;
    rv_issue_pkg::alu_entry_t    alu_entry;
    rv_issue_pkg::cmp_entry_t    cmp_entry;

    // Model state, predicted one cycle ahead
    logic exp_read  = 1'b0;
    logic exp_alu_v = 1'b0;
    logic exp_cmp_v = 1'b0;
    logic exp_rob_v = 1'b0;
    logic exp_rat_v = 1'b0;
    rv_issue_pkg::alu_entry_t  exp_alu;
    rv_issue_pkg::cmp_entry_t  exp_cmp;
    rv_issue_pkg::rob_entry_t  exp_rob;
    rv_issue_pkg::rat_update_t exp_rat;

    integer seed = 39;
    int strobe_errors = 0;
    int reg_errors = 0;
    int alu_errors = 0;
    int cmp_errors = 0;
    int rob_errors = 0;
    int rat_errors = 0;
    int wait_cycles;

    decode_issue decode_issue_i (
        .clk (clk), .rst (rst), .iq_valid_i (iq_valid), .iq_instr_i (iq_instr),
        .iq_pc_i (iq_pc), .iq_read_o (iq_read), .rs1_o (rs1), .rs2_o (rs2),
        .rf_val1_i (rf_val1), .rf_tag1_i (rf_tag1), .rf_val2_i (rf_val2),
        .rf_tag2_i (rf_tag2), .rat_we_o (rat_we), .rat_rd_o (rat_rd), .rat_tag_o (rat_tag),
        .rob_free_tag_i (rob_free_tag), .rob_done_i (rob_done), .rob_value_i (rob_value),
        .rob_we_o (rob_we), .rob_pc_o (rob_pc), .rob_opcode_o (rob_opcode),
        .rob_rd_o (rob_rd), .alu_full_i (alu_full), .cmp_full_i (cmp_full),
        .alu_valid_o (alu_valid), .alu_entry_o (alu_entry),
        .cmp_valid_o (cmp_valid), .cmp_entry_o (cmp_entry)
    );

    always #2 clk = ~clk;

    task automatic drive_inputs();
        rv_issue_pkg::word_t instr;
        rv_issue_pkg::word_t [rv_issue_pkg::ROB_DEPTH-1:0] vals;
        logic [31:0] r;
        logic [31:0] r2;
        instr = $random(seed);
        r = $random(seed);
        r2 = $random(seed);
        case (r[2:0])
            3'd0: instr[6:0] = rv_issue_pkg::OP_LUI;
            3'd1: instr[6:0] = rv_issue_pkg::OP_AUIPC;
            3'd2: instr[6:0] = rv_issue_pkg::OP_BR;
            3'd3, 3'd4: instr[6:0] = rv_issue_pkg::OP_IMM;
            3'd6: instr[6:0] = r[3] ? 7'b0000011 : 7'b1101111;   // load or JAL
            default: instr[6:0] = rv_issue_pkg::OP_REG;
        endcase
        if (instr[6:0] == rv_issue_pkg::OP_REG)
            instr[31:25] = {1'b0, r[4], 5'b00000};
        if (instr[6:0] == rv_issue_pkg::OP_BR && instr[14:13] == 2'b01)
            instr[14] = 1'b1;   // no branch funct3 010/011
        if (r[7:5] == 3'd0)
            instr[11:7] = '0;
        for (int k = 0; k < rv_issue_pkg::ROB_DEPTH; k++)
            vals[k] = $random(seed);
        iq_valid     <= (r[10:8] != 3'd0);
        iq_instr     <= instr;
        iq_pc        <= $random(seed) & 32'hffff_fffc;
        rf_val1      <= $random(seed);
        rf_val2      <= $random(seed);
        rf_tag1      <= r[14] ? r[13:11] : 3'd0;
        rf_tag2      <= r2[7] ? r2[10:8] : 3'd0;
        alu_full     <= (r2[1:0] == 2'b00);
        cmp_full     <= (r2[3:2] == 2'b00);
        rob_free_tag <= r2[6:4];            // zero means ROB full
        rob_done     <= r2[18:11];
        rob_value    <= vals;
    endtask

    function automatic rv_issue_pkg::operand_t forward(rv_issue_pkg::word_t val,
                                                       rv_issue_pkg::rob_tag_t tag);
        if (tag != 3'd0 && rob_done[tag])
            forward = '{value: rob_value[tag], ready: 1'b1, tag: 3'd0};
        else
            forward = '{value: val, ready: (tag == 3'd0), tag: tag};
    endfunction

    function automatic rv_issue_pkg::alu_op_t expected_alu_op(logic [2:0] f3, logic alt,
                                                              logic reg_form);
        case (f3)
            3'b000:  expected_alu_op = (reg_form && alt) ? rv_issue_pkg::ALU_SUB
                                                         : rv_issue_pkg::ALU_ADD;
            3'b001:  expected_alu_op = rv_issue_pkg::ALU_SLL;
            3'b100:  expected_alu_op = rv_issue_pkg::ALU_XOR;
            3'b101:  expected_alu_op = alt ? rv_issue_pkg::ALU_SRA : rv_issue_pkg::ALU_SRL;
            3'b110:  expected_alu_op = rv_issue_pkg::ALU_OR;
            default: expected_alu_op = rv_issue_pkg::ALU_AND;
        endcase
    endfunction

    // Applies the issue rules to the inputs now on the ports
    task automatic predict();
        logic [6:0] opc;
        logic [2:0] f3;
        logic is_alu;
        logic is_cmp;
        logic is_br;
        logic is_ui;
        logic discard;
        logic issue;
        rv_issue_pkg::reg_idx_t rd;
        rv_issue_pkg::word_t i_imm;
        rv_issue_pkg::word_t b_imm;
        rv_issue_pkg::word_t u_imm;
        rv_issue_pkg::operand_t s1;
        rv_issue_pkg::operand_t s2;
        rv_issue_pkg::operand_t imm_op;
        opc = iq_instr[6:0];
        f3  = iq_instr[14:12];
        rd  = iq_instr[11:7];
        i_imm = {{20{iq_instr[31]}}, iq_instr[31:20]};
        b_imm = {{20{iq_instr[31]}}, iq_instr[7], iq_instr[30:25], iq_instr[11:8], 1'b0};
        u_imm = {iq_instr[31:12], 12'h000};
        s1 = forward(rf_val1, rf_tag1);
        s2 = forward(rf_val2, rf_tag2);
        imm_op = '{value: i_imm, ready: 1'b1, tag: 3'd0};
        is_ui  = (opc == rv_issue_pkg::OP_LUI) || (opc == rv_issue_pkg::OP_AUIPC);
        is_br  = (opc == rv_issue_pkg::OP_BR);
        is_cmp = (opc == rv_issue_pkg::OP_IMM || opc == rv_issue_pkg::OP_REG)
                 && (f3 == 3'b010 || f3 == 3'b011);
        is_alu = is_ui || ((opc == rv_issue_pkg::OP_IMM || opc == rv_issue_pkg::OP_REG)
                           && !is_cmp);
        discard = iq_valid && (((is_alu || is_cmp) && rd == 5'd0)
                               || !(is_alu || is_cmp || is_br));
        issue = iq_valid && !discard && (is_alu ? !alu_full : !cmp_full)
                && (rob_free_tag != 3'd0);
        exp_read  = (issue || discard) && !rst;
        exp_alu_v = issue && is_alu && !rst;
        exp_cmp_v = issue && !is_alu && !rst;
        exp_rob_v = issue && !rst;
        exp_rat_v = issue && !is_br && !rst;
        exp_alu.rob_tag = rob_free_tag;
        if (is_ui) begin
            exp_alu.op   = rv_issue_pkg::ALU_ADD;
            exp_alu.src1 = '{value: (opc == rv_issue_pkg::OP_AUIPC) ? iq_pc : 32'h0,
                             ready: 1'b1, tag: 3'd0};
            exp_alu.src2 = '{value: u_imm, ready: 1'b1, tag: 3'd0};
        end else begin
            exp_alu.op   = expected_alu_op(f3, iq_instr[30], opc == rv_issue_pkg::OP_REG);
            exp_alu.src1 = s1;
            exp_alu.src2 = (opc == rv_issue_pkg::OP_REG) ? s2 : imm_op;
        end
        if (is_br)
            exp_cmp.op = rv_issue_pkg::cmp_op_t'(f3);
        else
            exp_cmp.op = (f3 == 3'b011) ? rv_issue_pkg::CMP_LTU : rv_issue_pkg::CMP_LT;
        exp_cmp.is_branch = is_br;
        exp_cmp.src1      = s1;
        exp_cmp.src2      = (opc == rv_issue_pkg::OP_IMM) ? imm_op : s2;
        exp_cmp.pc        = iq_pc;
        exp_cmp.b_imm     = is_br ? b_imm : 32'h0;
        exp_cmp.rob_tag   = rob_free_tag;
        exp_rob = '{pc: iq_pc, opcode: rv_issue_pkg::opcode_t'(opc), rd: is_br ? 5'd0 : rd};
        exp_rat = '{rd: rd, tag: rob_free_tag};
    endtask

    task automatic check_strobe(string name, logic got, logic want);
        if (got !== want) begin
            strobe_errors++;
            $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_reg(string name, rv_issue_pkg::reg_idx_t got,
                             rv_issue_pkg::reg_idx_t want);
        if (got !== want) begin
            reg_errors++;
            $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_alu(rv_issue_pkg::alu_entry_t got, rv_issue_pkg::alu_entry_t want);
        if (got !== want) begin
            alu_errors++;
            $display("Fail at %0d ns: ALU entry %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_cmp(rv_issue_pkg::cmp_entry_t got, rv_issue_pkg::cmp_entry_t want);
        if (got !== want) begin
            cmp_errors++;
            $display("Fail at %0d ns: compare entry %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_rob(rv_issue_pkg::rob_entry_t got, rv_issue_pkg::rob_entry_t want);
        if (got !== want) begin
            rob_errors++;
            $display("Fail at %0d ns: ROB entry %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_rat(rv_issue_pkg::rat_update_t got, rv_issue_pkg::rat_update_t want);
        if (got !== want) begin
            rat_errors++;
            $display("Fail at %0d ns: rename update %h, expected %h", $time, got, want);
        end
    endtask

    // Outputs from the last edge first, then the new prediction
    always @(negedge clk) begin
        check_strobe("alu_valid_o", alu_valid, exp_alu_v);
        check_strobe("cmp_valid_o", cmp_valid, exp_cmp_v);
        check_strobe("rob_we_o", rob_we, exp_rob_v);
        check_strobe("rat_we_o", rat_we, exp_rat_v);
        if (exp_alu_v)
            check_alu(alu_entry, exp_alu);
        if (exp_cmp_v)
            check_cmp(cmp_entry, exp_cmp);
        if (exp_rob_v)
            check_rob(rv_issue_pkg::rob_entry_t'{pc: rob_pc, opcode: rob_opcode, rd: rob_rd},
                      exp_rob);
        if (exp_rat_v)
            check_rat(rv_issue_pkg::rat_update_t'{rd: rat_rd, tag: rat_tag}, exp_rat);
        predict();
        check_strobe("iq_read_o", iq_read, exp_read);
        check_reg("rs1_o", rs1, iq_instr[19:15]);
        check_reg("rs2_o", rs2, iq_instr[24:20]);
    end

    initial begin
        rst = 1'b1;
        iq_valid = 1'b0;
        iq_instr = '0;
        iq_pc = '0;
        rf_val1 = '0;
        rf_val2 = '0;
        rf_tag1 = '0;
        rf_tag2 = '0;
        rob_free_tag = '0;
        rob_done = '0;
        rob_value = '0;
        alu_full = 1'b0;
        cmp_full = 1'b0;
        repeat (8) begin
            @(posedge clk);
            drive_inputs();     // Traffic during reset must not pop or issue
        end
        rst <= 1'b0;
        wait_cycles = 0;
        while (rst !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was not released after %0d cycles", RESET_TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (NUM_CYCLES) begin
                @(posedge clk);
                drive_inputs();
            end
            @(posedge clk);
            iq_valid <= 1'b0;   // drain the last strobes
            repeat (3) @(posedge clk);
            $display("Errors: strobe %0d, reg %0d, alu %0d, cmp %0d, rob %0d, rat %0d",
                     strobe_errors, reg_errors, alu_errors, cmp_errors, rob_errors,
                     rat_errors);
            if (strobe_errors + reg_errors + alu_errors + cmp_errors + rob_errors
                + rat_errors == 0)
                $display("Result: PASSED");
            else
                $display("Result: FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
verilog/rv_issue_pkg.sv
verilog/instr_fields.sv
verilog/operand_forward.sv
verilog/issue_control.sv
verilog/issue_slot.sv
verilog/decode_issue.sv
verification/decode_issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= decode_issue_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
